// File: dv/rv_decode_assertions.sv
module rv_decode_assertions (
    input logic i_clk,
    input logic i_arst_n,
    input logic i_valid,
    input logic o_valid,
    input logic o_supported,
    input logic o_reg_write,
    input logic o_inst_store,
    input logic o_inst_branch,
    input logic o_inst_jal,
    input logic o_inst_jalr
);

    logic any_flag;

    assign any_flag = o_reg_write | o_inst_store | o_inst_branch | o_inst_jal | o_inst_jalr;

    a_valid_latency: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_valid == $past(i_valid))
        else $error("o_valid does not follow i_valid by one cycle");

    a_unsupported_quiet: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !o_supported |-> !any_flag)
        else $error("unsupported word raised a flag");

    a_reset_quiet: assert property (@(posedge i_clk)
        !i_arst_n |-> (!o_valid && !any_flag && !o_supported))
        else $error("outputs active during reset");

endmodule

bind rv_decode rv_decode_assertions u_assertions (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_valid       (i_valid),
    .o_valid       (o_valid),
    .o_supported   (o_supported),
    .o_reg_write   (o_reg_write),
    .o_inst_store  (o_inst_store),
    .o_inst_branch (o_inst_branch),
    .o_inst_jal    (o_inst_jal),
    .o_inst_jalr   (o_inst_jalr)
);

// File: dv/rv_decode_checker.sv
module rv_decode_checker
    import rv_decode_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_arst_n,
    input  logic        i_valid,
    input  logic [31:0] i_instr,
    input  logic [31:0] i_pc,
    input  logic        o_valid,
    input  logic [31:0] o_pc,
    input  logic [4:0]  o_rd,
    input  logic [4:0]  o_rs1,
    input  logic [4:0]  o_rs2,
    input  logic [31:0] o_imm_i,
    input  logic [31:0] o_imm_j,
    input  logic [2:0]  o_funct3,
    input  logic        o_supported,
    input  logic        o_reg_write,
    input  logic        o_op1_pc,
    input  logic [1:0]  o_op2_src,
    input  logic [1:0]  o_res_src,
    input  logic [3:0]  o_alu_fn,
    input  logic        o_cmp_inv,
    input  logic        o_inst_jal,
    input  logic        o_inst_jalr,
    input  logic        o_inst_branch,
    input  logic        o_inst_store,
    input  logic [2:0]  i_test_id,
    input  logic        i_report,
    output logic        o_busy,
    output int          o_checks,
    output int          o_errors
);

    int          test_checks [0:5];
    int          test_errs [0:5];
    logic        pending;
    logic        seen;
    logic        e_sup, e_rw, e_op1, e_inv, e_jal, e_jalr, e_br, e_st;
    logic [1:0]  e_op2, e_res;
    logic [3:0]  e_alu;
    logic [4:0]  e_rd, e_rs1, e_rs2;
    logic [2:0]  e_f3;
    logic [31:0] e_imm_i, e_imm_j, e_pc;

    assign o_busy = pending;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd0:    return "reset_idle";
            3'd1:    return "latency_stream";
            3'd2:    return "class_decode";
            3'd3:    return "alu_function";
            3'd4:    return "fields_immediates";
            default: return "illegal_words";
        endcase
    endfunction

    task automatic check_field(input string fname, input logic [31:0] exp,
                               input logic [31:0] act);
        test_checks[i_test_id] = test_checks[i_test_id] + 1;
        o_checks = o_checks + 1;
        if (exp !== act) begin
            test_errs[i_test_id] = test_errs[i_test_id] + 1;
            o_errors = o_errors + 1;
            $display("CHECK FAILED %s %s expected %h actual %h",
                     test_name(i_test_id), fname, exp, act);
        end
    endtask

    // reference decode straight from the RV32I encoding rules
    task automatic model_decode(input logic [31:0] w, input logic [31:0] pc);
        logic       full, ld, st, opi, opr, br, jal, jalr, lui, aui, fen, alt;
        logic [4:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        full = (w[1:0] == 2'b11);
        opc  = w[6:2];
        f3   = w[14:12];
        f7   = w[31:25];
        alt  = (f7 == 7'b0100000);
        ld   = full && opc == 5'b00000 && (f3 <= 3'd2 || f3 == 3'd4 || f3 == 3'd5);
        st   = full && opc == 5'b01000 && f3 <= 3'd2;
        opi  = full && opc == 5'b00100 && (f3 != 3'd5 || f7 == 7'd0 || alt);
        opr  = full && opc == 5'b01100 && (f7 == 7'd0 || (alt && (f3 == 3'd0 || f3 == 3'd5)));
        br   = full && opc == 5'b11000 && f3 != 3'd2 && f3 != 3'd3;
        jalr = full && opc == 5'b11001 && f3 == 3'd0;
        jal  = full && opc == 5'b11011;
        lui  = full && opc == 5'b01101;
        aui  = full && opc == 5'b00101;
        fen  = full && opc == 5'b00011 && f3 <= 3'd1;
        e_sup  = ld | st | opi | opr | br | jalr | jal | lui | aui | fen | (w == 32'd0);
        e_rw   = ld | opi | opr | lui | aui | jal | jalr;
        e_op1  = aui | jal;
        e_op2  = jal ? OP2_JIMM : ((jalr | ld | opi | lui | aui | st) ? OP2_IMM : OP2_REG);
        e_res  = ld ? RES_MEM : ((jal | jalr) ? RES_PC_P4 : RES_ALU);
        e_jal  = jal;
        e_jalr = jalr;
        e_br   = br;
        e_st   = st;
        e_rd   = w[11:7];
        e_rs1  = lui ? 5'd0 : w[19:15];
        e_rs2  = w[24:20];
        e_f3   = f3;
        e_pc   = pc;
        if (lui | aui) begin
            e_imm_i = {w[31:12], 12'd0};
        end else if (st) begin
            e_imm_i = {{20{w[31]}}, w[31:25], w[11:7]};
        end else begin
            e_imm_i = {{20{w[31]}}, w[31:20]};
        end
        if (jal) begin
            e_imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end else begin
            e_imm_j = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end
        e_alu = ALU_ADD;
        e_inv = 1'b0;
        if (br) begin
            e_inv = f3[0];
            e_alu = (f3 <= 3'd1) ? ALU_EQ : ((f3 <= 3'd5) ? ALU_LTS : ALU_LTU);
        end else if (opi | opr) begin
            case (f3)
                3'd0:    e_alu = (opr && alt) ? ALU_SUB : ALU_ADD;
                3'd1:    e_alu = ALU_SHL;
                3'd2:    e_alu = ALU_LTS;
                3'd3:    e_alu = ALU_LTU;
                3'd4:    e_alu = ALU_XOR;
                3'd5:    e_alu = alt ? ALU_SHRA : ALU_SHRL;
                3'd6:    e_alu = ALU_OR;
                default: e_alu = ALU_AND;
            endcase
        end
    endtask

    initial begin
        for (int i = 0; i < 6; i++) begin
            test_checks[i] = 0;
            test_errs[i]   = 0;
        end
        o_checks = 0;
        o_errors = 0;
        pending  = 1'b0;
        seen     = 1'b0;
    end

    always @(posedge i_clk) begin
        pending = i_arst_n && i_valid;
        if (pending) begin
            seen = 1'b1;
            model_decode(i_instr, i_pc);
        end
    end

    // outputs settle well before the falling edge
    always @(negedge i_clk) begin
        if (!i_arst_n || !seen) begin
            check_field("idle o_valid", 32'd0, 32'(o_valid));
            check_field("idle o_supported", 32'd0, 32'(o_supported));
            check_field("idle o_reg_write", 32'd0, 32'(o_reg_write));
            check_field("idle o_op1_pc", 32'd0, 32'(o_op1_pc));
            check_field("idle o_cmp_inv", 32'd0, 32'(o_cmp_inv));
            check_field("idle jump/branch/store",
                        32'd0, 32'({o_inst_jal, o_inst_jalr, o_inst_branch, o_inst_store}));
            check_field("idle o_alu_fn", 32'(ALU_ADD), 32'(o_alu_fn));
        end else begin
            check_field("o_valid", 32'(pending), 32'(o_valid));
            // without a strobe the last decode must hold
            if (o_valid == pending) begin
                check_field("o_pc", e_pc, o_pc);
                check_field("o_supported", 32'(e_sup), 32'(o_supported));
                check_field("o_reg_write", 32'(e_rw), 32'(o_reg_write));
                check_field("o_op1_pc", 32'(e_op1), 32'(o_op1_pc));
                check_field("o_op2_src", 32'(e_op2), 32'(o_op2_src));
                check_field("o_res_src", 32'(e_res), 32'(o_res_src));
                check_field("o_alu_fn", 32'(e_alu), 32'(o_alu_fn));
                check_field("o_cmp_inv", 32'(e_inv), 32'(o_cmp_inv));
                check_field("o_inst_jal", 32'(e_jal), 32'(o_inst_jal));
                check_field("o_inst_jalr", 32'(e_jalr), 32'(o_inst_jalr));
                check_field("o_inst_branch", 32'(e_br), 32'(o_inst_branch));
                check_field("o_inst_store", 32'(e_st), 32'(o_inst_store));
                check_field("o_rd", 32'(e_rd), 32'(o_rd));
                check_field("o_rs1", 32'(e_rs1), 32'(o_rs1));
                check_field("o_rs2", 32'(e_rs2), 32'(o_rs2));
                check_field("o_funct3", 32'(e_f3), 32'(o_funct3));
                check_field("o_imm_i", e_imm_i, o_imm_i);
                check_field("o_imm_j", e_imm_j, o_imm_j);
            end
        end
    end

    always @(posedge i_report) begin
        $display("test %s done: %0d checks, %0d errors", test_name(i_test_id),
                 test_checks[i_test_id], test_errs[i_test_id]);
    end

endmodule

// File: dv/rv_decode_tb.sv
module rv_decode_tb
    import rv_decode_pkg::*;
;

    logic        clk;
    logic        arst_n;
    logic        valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [2:0]  test_id;
    logic        report;
    integer      seed;
    logic        busy;
    int          checks;
    int          errors;
    int          timeouts;

    logic                 o_valid, o_supported, o_reg_write, o_op1_pc, o_cmp_inv;
    logic                 o_inst_jal, o_inst_jalr, o_inst_branch, o_inst_store;
    logic [XLEN-1:0]      o_pc, o_imm_i, o_imm_j;
    logic [REG_IDX_W-1:0] o_rd, o_rs1, o_rs2;
    logic [2:0]           o_funct3;
    op2_src_e             o_op2_src;
    res_src_e             o_res_src;
    alu_fn_e              o_alu_fn;

    rv_decode dut (
        .i_clk(clk), .i_arst_n(arst_n), .i_valid(valid), .i_instr(instr), .i_pc(pc),
        .o_valid(o_valid), .o_pc(o_pc), .o_rd(o_rd), .o_rs1(o_rs1), .o_rs2(o_rs2),
        .o_imm_i(o_imm_i), .o_imm_j(o_imm_j), .o_funct3(o_funct3),
        .o_supported(o_supported), .o_reg_write(o_reg_write), .o_op1_pc(o_op1_pc),
        .o_op2_src(o_op2_src), .o_res_src(o_res_src), .o_alu_fn(o_alu_fn),
        .o_cmp_inv(o_cmp_inv), .o_inst_jal(o_inst_jal), .o_inst_jalr(o_inst_jalr),
        .o_inst_branch(o_inst_branch), .o_inst_store(o_inst_store)
    );

    rv_decode_checker u_checker (
        .i_clk(clk), .i_arst_n(arst_n), .i_valid(valid), .i_instr(instr), .i_pc(pc),
        .o_valid(o_valid), .o_pc(o_pc), .o_rd(o_rd), .o_rs1(o_rs1), .o_rs2(o_rs2),
        .o_imm_i(o_imm_i), .o_imm_j(o_imm_j), .o_funct3(o_funct3),
        .o_supported(o_supported), .o_reg_write(o_reg_write), .o_op1_pc(o_op1_pc),
        .o_op2_src(o_op2_src), .o_res_src(o_res_src), .o_alu_fn(o_alu_fn),
        .o_cmp_inv(o_cmp_inv), .o_inst_jal(o_inst_jal), .o_inst_jalr(o_inst_jalr),
        .o_inst_branch(o_inst_branch), .o_inst_store(o_inst_store),
        .i_test_id(test_id), .i_report(report), .o_busy(busy),
        .o_checks(checks), .o_errors(errors)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic pick(input int unsigned n, output int unsigned v);
        v = $unsigned($random(seed)) % n;
    endtask

    // random fields around one listed opcode, then patched to a legal encoding
    task automatic make_legal(input int unsigned k, output logic [31:0] w);
        w = $random(seed);
        w[1:0] = 2'b11;
        case (k)
            0: begin
                w[6:2] = OPC_LOAD;
                if (w[14:12] == 3'd3 || w[14:12] > 3'd5) w[14:12] = 3'd2;
            end
            1: begin
                w[6:2] = OPC_STORE;
                w[14] = 1'b0;
                if (w[13:12] == 2'b11) w[13] = 1'b0;
            end
            2: begin
                w[6:2] = OPC_OP_IMM;
                if (w[14:12] == 3'd5) w[31:25] = w[30] ? FUNCT7_ALT : 7'd0;
            end
            3: begin
                w[6:2] = OPC_OP;
                w[31:25] = (w[30] && (w[14:12] == 3'd0 || w[14:12] == 3'd5)) ?
                           FUNCT7_ALT : 7'd0;
            end
            4: w[6:2] = OPC_LUI;
            5: w[6:2] = OPC_AUIPC;
            6: begin
                w[6:2] = OPC_BRANCH;
                if (w[14:13] == 2'b01) w[13] = 1'b0;
            end
            7: w[6:2] = OPC_JAL;
            8: begin
                w[6:2] = OPC_JALR;
                w[14:12] = 3'd0;
            end
            default: begin
                w[6:2] = OPC_MISC_MEM;
                w[14:13] = 2'b00;
            end
        endcase
    endtask

    task automatic make_illegal(output logic [31:0] w);
        int unsigned kind;
        pick(6, kind);
        w = $random(seed);
        case (kind)
            0: w[31:0] = {7'h01, w[24:7], OPC_OP, 2'b11};   // M extension funct7
            1: w[31:0] = {w[31:15], (w[0] ? 3'd3 : 3'd7), w[11:7], OPC_LOAD, 2'b11};
            2: w[6:0] = {(w[8] ? 5'b01011 : 5'b10100), 2'b11};
            3: w = w[9] ? 32'h0000_0073 : 32'h0010_0073;    // ecall, ebreak
            4: w[1:0] = w[1] ? 2'b01 : 2'b10;
            default: w = 32'd0;
        endcase
    endtask

    task automatic make_word(input int mode, output logic [31:0] w);
        int unsigned k;
        int unsigned kind;
        pick(10, k);
        pick(4, kind);
        if (mode == 1) begin
            if (kind == 0) w = $random(seed);
            else if (kind == 1) w = 32'd0;
            else make_legal(k, w);
        end else if (mode == 3) begin
            if (kind == 0) make_legal(k, w);
            else if (kind == 1) make_legal(2, w);
            else if (kind == 2) make_legal(3, w);
            else make_legal(6, w);
        end else if (mode == 5) begin
            make_illegal(w);
        end else begin
            make_legal(k, w);
        end
    endtask

    task automatic strobe(input logic [31:0] w);
        @(posedge clk);
        #2;
        valid = 1'b1;
        instr = w;
        pc = $random(seed);
        pc[1:0] = 2'b00;
    endtask

    task automatic idle_cycles(input int unsigned n);
        repeat (n) begin
            @(posedge clk);
            #2;
            valid = 1'b0;
            instr = $random(seed);   // junk while idle
            pc    = $random(seed);
        end
    endtask

    task automatic finish_test();
        int t;
        idle_cycles(1);
        t = 0;
        while ((busy || o_valid) && t <= 50) begin
            @(negedge clk);
            t = t + 1;
        end
        if (busy || o_valid) begin
            timeouts = timeouts + 1;
            $display("timeout waiting for the decoder to drain");
        end
        #1;   // after the last negedge compare
        report = 1'b1;
        #1;
        report = 1'b0;
    endtask

    task automatic run_test(input logic [2:0] id, input int n);
        logic [31:0] w;
        int unsigned gap;
        test_id = id;
        for (int i = 0; i < n; i++) begin
            make_word(int'(id), w);
            strobe(w);
            pick(id == 3'd1 ? 4 : 2, gap);   // zero gap keeps strobes back to back
            idle_cycles(gap);
        end
        finish_test();
    endtask

    initial begin
        seed     = 32'h3ba34712;
        arst_n   = 1'b0;
        valid    = 1'b0;
        instr    = 32'd0;
        pc       = 32'd0;
        test_id  = 3'd0;
        report   = 1'b0;
        timeouts = 0;
        repeat (10) @(posedge clk);
        #2;
        arst_n = 1'b1;
        idle_cycles(4);
        finish_test();
        run_test(3'd1, 80);
        run_test(3'd2, 150);
        run_test(3'd3, 150);
        run_test(3'd4, 150);
        run_test(3'd5, 120);
        $display("tests 6, checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: run.sh
#!/bin/sh
# build and run the decoder testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f rv_decode.f --top-module rv_decode_tb \
    -o sim_rv_decode || { echo "build error"; exit 1; }
./obj_dir/sim_rv_decode > sim.log 2>&1
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || { echo "run ended without a result"; exit 1; }
exit 0

// File: rv_decode.f
verilog/rv_decode_pkg.sv
verilog/rv_op_decoder.sv
verilog/rv_imm_gen.sv
verilog/rv_alu_op_encoder.sv
verilog/rv_decode_stage_reg.sv
verilog/rv_decode.sv
dv/rv_decode_checker.sv
dv/rv_decode_assertions.sv
dv/rv_decode_tb.sv

// File: verilog/rv_alu_op_encoder.sv
module rv_alu_op_encoder
    import rv_decode_pkg::*;
(
    input  rv_instr_u i_instr,
    input  logic      i_is_branch,
    input  logic      i_is_op_imm,
    input  logic      i_is_op_reg,
    output alu_fn_e   o_alu_fn,
    output logic      o_cmp_inv
);

    logic [2:0] funct3;
    logic       alt;

    assign funct3 = i_instr.r.funct3;
    // funct7 already validated upstream, the alternate bit is enough
    assign alt    = |(i_instr.r.funct7 & FUNCT7_ALT);

    always_comb begin
        o_alu_fn  = ALU_ADD;
        o_cmp_inv = 1'b0;
        if (i_is_branch) begin
            o_cmp_inv = funct3[0];   // bne, bge, bgeu
            case (funct3[2:1])
                2'b00:   o_alu_fn = ALU_EQ;
                2'b10:   o_alu_fn = ALU_LTS;
                2'b11:   o_alu_fn = ALU_LTU;
                default: o_alu_fn = ALU_ADD;
            endcase
        end else if (i_is_op_imm || i_is_op_reg) begin
            case (funct3)
                3'd0: begin
                    // addi has no sub form
                    if (i_is_op_reg && alt) begin
                        o_alu_fn = ALU_SUB;
                    end
                end
                3'd1:    o_alu_fn = ALU_SHL;
                3'd2:    o_alu_fn = ALU_LTS;
                3'd3:    o_alu_fn = ALU_LTU;
                3'd4:    o_alu_fn = ALU_XOR;
                3'd5:    o_alu_fn = alt ? ALU_SHRA : ALU_SHRL;
                3'd6:    o_alu_fn = ALU_OR;
                default: o_alu_fn = ALU_AND;
            endcase
        end
    end

endmodule

// File: verilog/rv_decode.sv
module rv_decode
    import rv_decode_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_arst_n,
    input  logic                  i_valid,
    input  rv_instr_u             i_instr,
    input  logic [XLEN-1:0]       i_pc,
    output logic                  o_valid,
    output logic [XLEN-1:0]       o_pc,
    output logic [REG_IDX_W-1:0]  o_rd,
    output logic [REG_IDX_W-1:0]  o_rs1,
    output logic [REG_IDX_W-1:0]  o_rs2,
    output logic [XLEN-1:0]       o_imm_i,
    output logic [XLEN-1:0]       o_imm_j,
    output logic [2:0]            o_funct3,
    output logic                  o_supported,
    output logic                  o_reg_write,
    output logic                  o_op1_pc,
    output op2_src_e              o_op2_src,
    output res_src_e              o_res_src,
    output alu_fn_e               o_alu_fn,
    output logic                  o_cmp_inv,
    output logic                  o_inst_jal,
    output logic                  o_inst_jalr,
    output logic                  o_inst_branch,
    output logic                  o_inst_store
);

    logic            supported;
    logic            is_store;
    logic            is_branch;
    logic            is_jal;
    logic            is_jalr;
    logic            is_lui;
    logic            is_op_imm;
    logic            is_op_reg;
    logic            reg_write;
    logic            op1_pc;
    op2_src_e        op2_src;
    res_src_e        res_src;
    imm_sel_e        imm_sel;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_j;
    alu_fn_e         alu_fn;
    logic            cmp_inv;

    rv_op_decoder u_op_decoder (
        .i_instr     (i_instr),
        .o_supported (supported),
        .o_is_load   (),          // load only steers the result source inside
        .o_is_store  (is_store),
        .o_is_branch (is_branch),
        .o_is_jal    (is_jal),
        .o_is_jalr   (is_jalr),
        .o_is_lui    (is_lui),
        .o_is_op_imm (is_op_imm),
        .o_is_op_reg (is_op_reg),
        .o_reg_write (reg_write),
        .o_op1_pc    (op1_pc),
        .o_op2_src   (op2_src),
        .o_res_src   (res_src),
        .o_imm_sel   (imm_sel)
    );

    rv_imm_gen u_imm_gen (
        .i_instr   (i_instr),
        .i_imm_sel (imm_sel),
        .i_is_jal  (is_jal),
        .o_imm_i   (imm_i),
        .o_imm_j   (imm_j)
    );

    rv_alu_op_encoder u_alu_op_encoder (
        .i_instr     (i_instr),
        .i_is_branch (is_branch),
        .i_is_op_imm (is_op_imm),
        .i_is_op_reg (is_op_reg),
        .o_alu_fn    (alu_fn),
        .o_cmp_inv   (cmp_inv)
    );

    rv_decode_stage_reg u_stage_reg (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_valid       (i_valid),
        .i_pc          (i_pc),
        .i_instr       (i_instr),
        .i_imm_i       (imm_i),
        .i_imm_j       (imm_j),
        .i_supported   (supported),
        .i_reg_write   (reg_write),
        .i_op1_pc      (op1_pc),
        .i_op2_src     (op2_src),
        .i_res_src     (res_src),
        .i_alu_fn      (alu_fn),
        .i_cmp_inv     (cmp_inv),
        .i_is_jal      (is_jal),
        .i_is_jalr     (is_jalr),
        .i_is_branch   (is_branch),
        .i_is_store    (is_store),
        .i_is_lui      (is_lui),
        .o_valid       (o_valid),
        .o_pc          (o_pc),
        .o_rd          (o_rd),
        .o_rs1         (o_rs1),
        .o_rs2         (o_rs2),
        .o_imm_i       (o_imm_i),
        .o_imm_j       (o_imm_j),
        .o_funct3      (o_funct3),
        .o_supported   (o_supported),
        .o_reg_write   (o_reg_write),
        .o_op1_pc      (o_op1_pc),
        .o_op2_src     (o_op2_src),
        .o_res_src     (o_res_src),
        .o_alu_fn      (o_alu_fn),
        .o_cmp_inv     (o_cmp_inv),
        .o_inst_jal    (o_inst_jal),
        .o_inst_jalr   (o_inst_jalr),
        .o_inst_branch (o_inst_branch),
        .o_inst_store  (o_inst_store)
    );

endmodule

// File: verilog/rv_decode_pkg.sv
package rv_decode_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;

    // major opcodes, instr[6:2]
    localparam logic [4:0] OPC_LOAD     = 5'b00000;
    localparam logic [4:0] OPC_MISC_MEM = 5'b00011;
    localparam logic [4:0] OPC_OP_IMM   = 5'b00100;
    localparam logic [4:0] OPC_AUIPC    = 5'b00101;
    localparam logic [4:0] OPC_STORE    = 5'b01000;
    localparam logic [4:0] OPC_OP       = 5'b01100;
    localparam logic [4:0] OPC_LUI      = 5'b01101;
    localparam logic [4:0] OPC_BRANCH   = 5'b11000;
    localparam logic [4:0] OPC_JALR     = 5'b11001;
    localparam logic [4:0] OPC_JAL      = 5'b11011;

    localparam logic [1:0] OPC_FULL_LOW = 2'b11;   // anything else is compressed
    localparam logic [6:0] FUNCT7_ALT   = 7'b0100000;   // sub / sra / srai

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_fmt_t;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_u_fmt_t;

    // one fetched word, read through whichever format fits
    typedef union packed {
        rv_r_fmt_t r;
        rv_i_fmt_t i;
        rv_u_fmt_t u;
    } rv_instr_u;

    typedef enum logic [1:0] {
        OP2_REG,
        OP2_IMM,
        OP2_JIMM
    } op2_src_e;

    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_PC_P4   // link address for jal/jalr
    } res_src_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SHL,
        ALU_SHRL,
        ALU_SHRA,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_EQ,
        ALU_LTS,
        ALU_LTU
    } alu_fn_e;

    typedef enum logic [1:0] {
        IMM_I,
        IMM_S,
        IMM_U
    } imm_sel_e;

endpackage

// File: verilog/rv_decode_stage_reg.sv
module rv_decode_stage_reg
    import rv_decode_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_arst_n,
    input  logic                  i_valid,
    input  logic [XLEN-1:0]       i_pc,
    input  rv_instr_u             i_instr,
    input  logic [XLEN-1:0]       i_imm_i,
    input  logic [XLEN-1:0]       i_imm_j,
    input  logic                  i_supported,
    input  logic                  i_reg_write,
    input  logic                  i_op1_pc,
    input  op2_src_e              i_op2_src,
    input  res_src_e              i_res_src,
    input  alu_fn_e               i_alu_fn,
    input  logic                  i_cmp_inv,
    input  logic                  i_is_jal,
    input  logic                  i_is_jalr,
    input  logic                  i_is_branch,
    input  logic                  i_is_store,
    input  logic                  i_is_lui,
    output logic                  o_valid,
    output logic [XLEN-1:0]       o_pc,
    output logic [REG_IDX_W-1:0]  o_rd,
    output logic [REG_IDX_W-1:0]  o_rs1,
    output logic [REG_IDX_W-1:0]  o_rs2,
    output logic [XLEN-1:0]       o_imm_i,
    output logic [XLEN-1:0]       o_imm_j,
    output logic [2:0]            o_funct3,
    output logic                  o_supported,
    output logic                  o_reg_write,
    output logic                  o_op1_pc,
    output op2_src_e              o_op2_src,
    output res_src_e              o_res_src,
    output alu_fn_e               o_alu_fn,
    output logic                  o_cmp_inv,
    output logic                  o_inst_jal,
    output logic                  o_inst_jalr,
    output logic                  o_inst_branch,
    output logic                  o_inst_store
);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid       <= 1'b0;
            o_supported   <= 1'b0;
            o_reg_write   <= 1'b0;
            o_op1_pc      <= 1'b0;
            o_op2_src     <= OP2_REG;
            o_res_src     <= RES_ALU;
            o_alu_fn      <= ALU_ADD;
            o_cmp_inv     <= 1'b0;
            o_inst_jal    <= 1'b0;
            o_inst_jalr   <= 1'b0;
            o_inst_branch <= 1'b0;
            o_inst_store  <= 1'b0;
        end else begin
            o_valid <= i_valid;   // one pulse per strobe
            if (i_valid) begin
                o_supported   <= i_supported;
                o_reg_write   <= i_reg_write;
                o_op1_pc      <= i_op1_pc;
                o_op2_src     <= i_op2_src;
                o_res_src     <= i_res_src;
                o_alu_fn      <= i_alu_fn;
                o_cmp_inv     <= i_cmp_inv;
                o_inst_jal    <= i_is_jal;
                o_inst_jalr   <= i_is_jalr;
                o_inst_branch <= i_is_branch;
                o_inst_store  <= i_is_store;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_pc     <= i_pc;
            o_rd     <= i_instr.r.rd;
            o_rs1    <= i_is_lui ? '0 : i_instr.r.rs1;   // lui adds to x0
            o_rs2    <= i_instr.r.rs2;
            o_imm_i  <= i_imm_i;
            o_imm_j  <= i_imm_j;
            o_funct3 <= i_instr.r.funct3;
        end
    end

endmodule

// File: verilog/rv_imm_gen.sv
module rv_imm_gen
    import rv_decode_pkg::*;
(
    input  rv_instr_u        i_instr,
    input  imm_sel_e         i_imm_sel,
    input  logic             i_is_jal,
    output logic [XLEN-1:0]  o_imm_i,
    output logic [XLEN-1:0]  o_imm_j
);

    logic [XLEN-1:0] imm_i_fmt;
    logic [XLEN-1:0] imm_s_fmt;
    logic [XLEN-1:0] imm_u_fmt;
    logic [XLEN-1:0] imm_b_fmt;
    logic [XLEN-1:0] imm_j_fmt;

    assign imm_i_fmt = {{20{i_instr.i.imm12[11]}}, i_instr.i.imm12};
    assign imm_s_fmt = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_u_fmt = {i_instr.u.imm20, 12'd0};   // low bits zero filled

    // branch and jump offsets are halfword aligned
    assign imm_b_fmt = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
    assign imm_j_fmt = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};

    always_comb begin
        case (i_imm_sel)
            IMM_U:   o_imm_i = imm_u_fmt;
            IMM_S:   o_imm_i = imm_s_fmt;
            default: o_imm_i = imm_i_fmt;
        endcase
    end

    assign o_imm_j = i_is_jal ? imm_j_fmt : imm_b_fmt;

endmodule

// File: verilog/rv_op_decoder.sv
module rv_op_decoder
    import rv_decode_pkg::*;
(
    input  rv_instr_u i_instr,
    output logic      o_supported,
    output logic      o_is_load,
    output logic      o_is_store,
    output logic      o_is_branch,
    output logic      o_is_jal,
    output logic      o_is_jalr,
    output logic      o_is_lui,
    output logic      o_is_op_imm,
    output logic      o_is_op_reg,
    output logic      o_reg_write,
    output logic      o_op1_pc,
    output op2_src_e  o_op2_src,
    output res_src_e  o_res_src,
    output imm_sel_e  o_imm_sel
);

    logic       full;
    logic [4:0] opc;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_ok;
    logic       is_auipc;
    logic       is_misc_mem;
    logic       recognized;

    assign full   = (i_instr.r.opcode[1:0] == OPC_FULL_LOW);
    assign opc    = i_instr.r.opcode[6:2];
    assign funct3 = i_instr.r.funct3;
    assign funct7 = i_instr.r.funct7;
    assign f7_ok  = (funct7 == 7'd0) || (funct7 == FUNCT7_ALT);

    always_comb begin
        o_is_load   = 1'b0;
        o_is_store  = 1'b0;
        o_is_branch = 1'b0;
        o_is_jal    = 1'b0;
        o_is_jalr   = 1'b0;
        o_is_lui    = 1'b0;
        o_is_op_imm = 1'b0;
        o_is_op_reg = 1'b0;
        is_auipc    = 1'b0;
        is_misc_mem = 1'b0;
        if (full) begin
            case (opc)
                OPC_LOAD:     o_is_load   = (funct3 != 3'd3) && (funct3 < 3'd6);
                OPC_STORE:    o_is_store  = (funct3 < 3'd3);
                OPC_OP_IMM:   o_is_op_imm = (funct3 != 3'd5) || f7_ok;   // shift imm
                OPC_OP: begin
                    // alt funct7 only for sub and sra
                    o_is_op_reg = (funct7 == 7'd0) ||
                                  ((funct7 == FUNCT7_ALT) &&
                                   ((funct3 == 3'd0) || (funct3 == 3'd5)));
                end
                OPC_BRANCH:   o_is_branch = (funct3[2:1] != 2'b01);
                OPC_JALR:     o_is_jalr   = (funct3 == 3'd0);
                OPC_JAL:      o_is_jal    = 1'b1;
                OPC_LUI:      o_is_lui    = 1'b1;
                OPC_AUIPC:    is_auipc    = 1'b1;
                OPC_MISC_MEM: is_misc_mem = (funct3[2:1] == 2'b00);   // fence, fence.i
                default: ;
            endcase
        end
    end

    assign recognized = o_is_load | o_is_store | o_is_branch | o_is_jal | o_is_jalr |
                        o_is_lui | is_auipc | o_is_op_imm | o_is_op_reg | is_misc_mem;

    // all-zero word is a bubble
    assign o_supported = recognized || (i_instr == '0);

    assign o_reg_write = o_is_load | o_is_op_imm | o_is_op_reg | o_is_lui | is_auipc |
                         o_is_jal | o_is_jalr;
    assign o_op1_pc    = is_auipc | o_is_jal;

    always_comb begin
        if (o_is_jal) begin
            o_op2_src = OP2_JIMM;
        end else if (o_is_jalr | o_is_load | o_is_op_imm | o_is_lui | is_auipc | o_is_store) begin
            o_op2_src = OP2_IMM;
        end else begin
            o_op2_src = OP2_REG;
        end
    end

    always_comb begin
        if (o_is_load) begin
            o_res_src = RES_MEM;
        end else if (o_is_jal | o_is_jalr) begin
            o_res_src = RES_PC_P4;
        end else begin
            o_res_src = RES_ALU;
        end
    end

    always_comb begin
        if (o_is_lui | is_auipc) begin
            o_imm_sel = IMM_U;
        end else if (o_is_store) begin
            o_imm_sel = IMM_S;
        end else begin
            o_imm_sel = IMM_I;
        end
    end

endmodule
